// File: common/pwm_pkg.sv
//----------------------------------------------------------------------
// shared definitions for the masked pairwise multiplier
// modulus, share width, latencies, register map, mod q add/sub helpers
//----------------------------------------------------------------------
package pwm_pkg;

    localparam int unsigned COEFF_WIDTH = 12;
    localparam logic [COEFF_WIDTH-1:0] MLKEM_Q = 12'd3329;

    // pipeline latencies in clock cycles
    localparam int unsigned MULT_LATENCY = 2;
    localparam int unsigned MASKED_MULT_LATENCY = 3;
    localparam int unsigned PWM_LATENCY = 8;

    // fresh random values per cycle, one per masked multiplier
    localparam int unsigned NUM_RND = 5;

    //------------------------------------------------------------------
    // register map, word addresses
    //------------------------------------------------------------------
    localparam int unsigned WB_ADDR_WIDTH = 5;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_CTRL = 5'd0;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_STATUS = 5'd1;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_OPERAND_BASE = 5'd2;
    localparam logic [WB_ADDR_WIDTH-1:0] REG_RESULT_BASE = 5'd16;
    localparam int unsigned NUM_OPERAND_WORDS = 14;
    localparam int unsigned NUM_RESULT_WORDS = 4;

    // (a + b) mod q, both inputs below q
    function automatic logic [COEFF_WIDTH-1:0] add_mod(input logic [COEFF_WIDTH-1:0] a,
                                                       input logic [COEFF_WIDTH-1:0] b);
        logic [COEFF_WIDTH:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, MLKEM_Q})
            s = s - {1'b0, MLKEM_Q};
        return s[COEFF_WIDTH-1:0];
    endfunction

    // (a - b) mod q, both inputs below q
    function automatic logic [COEFF_WIDTH-1:0] sub_mod(input logic [COEFF_WIDTH-1:0] a,
                                                       input logic [COEFF_WIDTH-1:0] b);
        logic [COEFF_WIDTH-1:0] d;
        d = a - b;
        // wraps mod 2^12, adding q lands back in range
        if (a < b)
            d = d + MLKEM_Q;
        return d;
    endfunction

endpackage

// File: rtl/mod_q_mult.sv
//----------------------------------------------------------------------
// pipelined modular multiplier
// stage 1 raw product, stage 2 Barrett reduction mod q
//----------------------------------------------------------------------
`timescale 1ns/1ns

module mod_q_mult (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  a,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  b,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]  p
);

    // floor(2^24 / q)
    localparam logic [12:0] BARRETT_M = 13'd5039;

    logic [23:0] prod;
    logic [36:0] quot_full;
    logic [11:0] quot;
    logic [23:0] rem_full;
    logic [12:0] rem;

    // quotient estimate is low by at most one, so rem stays below 2q
    always_comb begin
        quot_full = 37'(prod) * 37'(BARRETT_M);
        quot = quot_full[35:24];
        rem_full = prod - 24'(quot) * 24'(pwm_pkg::MLKEM_Q);
        rem = rem_full[12:0];
        if (rem >= {1'b0, pwm_pkg::MLKEM_Q})
            rem = rem - {1'b0, pwm_pkg::MLKEM_Q};
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod <= '0;
            p <= '0;
        end else if (zeroize) begin
            prod <= '0;
            p <= '0;
        end else begin
            prod <= 24'(a) * 24'(b);
            p <= rem[pwm_pkg::COEFF_WIDTH-1:0];
        end
    end

endmodule

// File: pairwm/masked_share_mult.sv
//----------------------------------------------------------------------
// two-share masked multiplier mod q
// four cross products, then a refresh-add with one random value
//----------------------------------------------------------------------
`timescale 1ns/1ns

module masked_share_mult (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  x_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  x_s1,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  y_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  y_s1,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  rnd,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]  z_s0,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]  z_s1
);

    localparam int unsigned W = pwm_pkg::COEFF_WIDTH;
    localparam int unsigned ML = pwm_pkg::MULT_LATENCY;

    logic [W-1:0] x0y0;
    logic [W-1:0] x0y1;
    logic [W-1:0] x1y0;
    logic [W-1:0] x1y1;
    logic [ML-1:0][W-1:0] rnd_d;

    mod_q_mult u_x0y0 (.clk, .reset_n, .zeroize, .a(x_s0), .b(y_s0), .p(x0y0));
    mod_q_mult u_x0y1 (.clk, .reset_n, .zeroize, .a(x_s0), .b(y_s1), .p(x0y1));
    mod_q_mult u_x1y0 (.clk, .reset_n, .zeroize, .a(x_s1), .b(y_s0), .p(x1y0));
    mod_q_mult u_x1y1 (.clk, .reset_n, .zeroize, .a(x_s1), .b(y_s1), .p(x1y1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rnd_d <= '0;
            z_s0 <= '0;
            z_s1 <= '0;
        end else if (zeroize) begin
            rnd_d <= '0;
            z_s0 <= '0;
            z_s1 <= '0;
        end else begin
            // mask travels alongside the products
            rnd_d <= {rnd_d[ML-2:0], rnd};
            // r enters one share and leaves the other, sum is unchanged
            // cross terms are refreshed before they meet the other product
            z_s0 <= pwm_pkg::add_mod(x0y0, pwm_pkg::add_mod(x0y1, rnd_d[ML-1]));
            z_s1 <= pwm_pkg::add_mod(x1y1, pwm_pkg::sub_mod(x1y0, rnd_d[ML-1]));
        end
    end

endmodule

// File: pairwm/masked_pairwm.sv
//----------------------------------------------------------------------
// masked pairwise multiply-accumulate in the NTT domain
// c0 = u0 v0 + u1 (zeta v1) + w0, c1 = u0 v1 + u1 v0 + w1
// fully pipelined, one item per cycle, 8 cycle latency
//----------------------------------------------------------------------
`timescale 1ns/1ns

module masked_pairwm (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize,
    input  logic                             in_valid,
    input  logic                             accumulate,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  u0_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  u0_s1,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  u1_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  u1_s1,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  v0_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  v0_s1,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  v1_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  v1_s1,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  w0_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  w0_s1,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  w1_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  w1_s1,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  zeta_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]  zeta_s1,
    input  logic [pwm_pkg::NUM_RND-1:0][pwm_pkg::COEFF_WIDTH-1:0] rnd,
    output logic                             out_valid,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]  res0_s0,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]  res0_s1,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]  res1_s0,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]  res1_s1
);

    localparam int unsigned W = pwm_pkg::COEFF_WIDTH;
    localparam int unsigned MD = pwm_pkg::MASKED_MULT_LATENCY;
    localparam int unsigned LAT = pwm_pkg::PWM_LATENCY;

    logic [W-1:0] u0v0_s0, u0v0_s1, u0v1_s0, u0v1_s1, u1v0_s0, u1v0_s1;
    logic [W-1:0] zv1_s0, zv1_s1, u1zv1_s0, u1zv1_s1;
    logic [W-1:0] uv0_s0, uv0_s1, uv1_s0, uv1_s1;

    // delay lines, index 0 is the newest entry
    logic [MD-1:0][1:0][W-1:0] u1_d;
    logic [MD-1:0][5:0][W-1:0] prod_d;
    logic [LAT-2:0][3:0][W-1:0] w_d;
    logic [LAT-2:0] acc_d;
    logic [LAT-1:0] valid_sr;

    //------------------------------------------------------------------
    // cycles 1-3, first rank of products
    //------------------------------------------------------------------
    masked_share_mult u_u0v0 (.clk, .reset_n, .zeroize, .x_s0(u0_s0), .x_s1(u0_s1),
        .y_s0(v0_s0), .y_s1(v0_s1), .rnd(rnd[0]), .z_s0(u0v0_s0), .z_s1(u0v0_s1));
    masked_share_mult u_u0v1 (.clk, .reset_n, .zeroize, .x_s0(u0_s0), .x_s1(u0_s1),
        .y_s0(v1_s0), .y_s1(v1_s1), .rnd(rnd[1]), .z_s0(u0v1_s0), .z_s1(u0v1_s1));
    masked_share_mult u_u1v0 (.clk, .reset_n, .zeroize, .x_s0(u1_s0), .x_s1(u1_s1),
        .y_s0(v0_s0), .y_s1(v0_s1), .rnd(rnd[2]), .z_s0(u1v0_s0), .z_s1(u1v0_s1));
    masked_share_mult u_zv1 (.clk, .reset_n, .zeroize, .x_s0(zeta_s0), .x_s1(zeta_s1),
        .y_s0(v1_s0), .y_s1(v1_s1), .rnd(rnd[3]), .z_s0(zv1_s0), .z_s1(zv1_s1));

    // cycles 4-6, u1 times zeta v1
    masked_share_mult u_u1zv1 (.clk, .reset_n, .zeroize,
        .x_s0(u1_d[MD-1][0]), .x_s1(u1_d[MD-1][1]), .y_s0(zv1_s0), .y_s1(zv1_s1),
        .rnd(rnd[4]), .z_s0(u1zv1_s0), .z_s1(u1zv1_s1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            u1_d <= '0;
            prod_d <= '0;
            w_d <= '0;
            acc_d <= '0;
            valid_sr <= '0;
            {uv0_s0, uv0_s1, uv1_s0, uv1_s1} <= '0;
            {res0_s0, res0_s1, res1_s0, res1_s1} <= '0;
        end else if (zeroize) begin
            u1_d <= '0;
            prod_d <= '0;
            w_d <= '0;
            acc_d <= '0;
            valid_sr <= '0;
            {uv0_s0, uv0_s1, uv1_s0, uv1_s1} <= '0;
            {res0_s0, res0_s1, res1_s0, res1_s1} <= '0;
        end else begin
            u1_d <= {u1_d[MD-2:0], {u1_s1, u1_s0}};
            prod_d <= {prod_d[MD-2:0], {u1v0_s1, u1v0_s0, u0v1_s1, u0v1_s0, u0v0_s1, u0v0_s0}};
            w_d <= {w_d[LAT-3:0], {w1_s1, w1_s0, w0_s1, w0_s0}};
            acc_d <= {acc_d[LAT-3:0], accumulate};
            valid_sr <= {valid_sr[LAT-2:0], in_valid};

            // cycle 7, share-wise coefficient sums
            uv0_s0 <= pwm_pkg::add_mod(prod_d[MD-1][0], u1zv1_s0);
            uv0_s1 <= pwm_pkg::add_mod(prod_d[MD-1][1], u1zv1_s1);
            uv1_s0 <= pwm_pkg::add_mod(prod_d[MD-1][2], prod_d[MD-1][4]);
            uv1_s1 <= pwm_pkg::add_mod(prod_d[MD-1][3], prod_d[MD-1][5]);

            // cycle 8, optional accumulate with the item's own flag
            res0_s0 <= pwm_pkg::add_mod(uv0_s0, acc_d[LAT-2] ? w_d[LAT-2][0] : '0);
            res0_s1 <= pwm_pkg::add_mod(uv0_s1, acc_d[LAT-2] ? w_d[LAT-2][1] : '0);
            res1_s0 <= pwm_pkg::add_mod(uv1_s0, acc_d[LAT-2] ? w_d[LAT-2][2] : '0);
            res1_s1 <= pwm_pkg::add_mod(uv1_s1, acc_d[LAT-2] ? w_d[LAT-2][3] : '0);
        end
    end

    assign out_valid = valid_sr[LAT-1];

endmodule

// File: rtl/mask_lfsr.sv
//----------------------------------------------------------------------
// free-running randomness source for mask refresh
// 64-bit Galois LFSR, NUM_RND values below q every cycle
//----------------------------------------------------------------------
`timescale 1ns/1ns

module mask_lfsr #(
    parameter logic [63:0] SEED = 64'h3c5a_96e1_0f27_b4d9
) (
    input  logic clk,
    input  logic reset_n,
    output logic [pwm_pkg::NUM_RND-1:0][pwm_pkg::COEFF_WIDTH-1:0] rnd
);

    localparam int unsigned W = pwm_pkg::COEFF_WIDTH;
    // x^64 + x^63 + x^61 + x^60 + 1, right-shift form
    localparam logic [63:0] TAPS = 64'hd800_0000_0000_0000;

    logic [63:0] state;
    logic [63:0] state_next;

    // W steps per cycle so each output field gets all new bits
    always_comb begin
        state_next = state;
        for (int i = 0; i < W; i++) begin
            state_next = {1'b0, state_next[63:1]} ^ (state_next[0] ? TAPS : 64'd0);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state <= SEED;
        else
            state <= state_next;
    end

    // one conditional subtraction, 4095 - q is already below q
    always_comb begin
        for (int i = 0; i < pwm_pkg::NUM_RND; i++) begin
            rnd[i] = state[i*W +: W];
            if (rnd[i] >= pwm_pkg::MLKEM_Q)
                rnd[i] = rnd[i] - pwm_pkg::MLKEM_Q;
        end
    end

endmodule

// File: rtl/pwm_regs.sv
//----------------------------------------------------------------------
// Wishbone classic register block
// operand and result storage, control, status, start/zeroize pulses
//----------------------------------------------------------------------
`timescale 1ns/1ns

module pwm_regs (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [pwm_pkg::WB_ADDR_WIDTH-1:0]  wb_adr,
    input  logic [31:0]                        wb_dat_w,
    output logic [31:0]                        wb_dat_r,
    output logic                               wb_ack,
    input  logic                               out_valid,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]    res0_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]    res0_s1,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]    res1_s0,
    input  logic [pwm_pkg::COEFF_WIDTH-1:0]    res1_s1,
    output logic                               zeroize,
    output logic                               in_valid,
    output logic                               accumulate,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    u0_s0,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    u0_s1,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    u1_s0,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    u1_s1,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    v0_s0,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    v0_s1,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    v1_s0,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    v1_s1,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    w0_s0,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    w0_s1,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    w1_s0,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    w1_s1,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    zeta_s0,
    output logic [pwm_pkg::COEFF_WIDTH-1:0]    zeta_s1
);

    localparam int unsigned W = pwm_pkg::COEFF_WIDTH;

    logic [pwm_pkg::NUM_OPERAND_WORDS-1:0][W-1:0] operand;
    logic [pwm_pkg::NUM_RESULT_WORDS-1:0][W-1:0] result;
    logic acc_q;
    logic busy;
    logic done;
    logic wb_req;
    logic ctrl_wr;
    logic zero_req;
    logic op_sel;
    logic res_sel;
    logic [pwm_pkg::WB_ADDR_WIDTH-1:0] op_off;
    logic [pwm_pkg::WB_ADDR_WIDTH-1:0] res_off;
    logic [31:0] rd_data;

    // new request only while ack is low
    assign wb_req = wb_cyc & wb_stb & ~wb_ack;
    assign ctrl_wr = wb_req & wb_we & (wb_adr == pwm_pkg::REG_CTRL);
    assign zero_req = ctrl_wr & wb_dat_w[2];

    // start goes straight into the pipeline, done follows 8 cycles after the ack
    assign in_valid = ctrl_wr & wb_dat_w[0] & ~wb_dat_w[2] & ~busy;
    assign accumulate = ctrl_wr ? wb_dat_w[1] : acc_q;

    assign op_off = wb_adr - pwm_pkg::REG_OPERAND_BASE;
    assign res_off = wb_adr - pwm_pkg::REG_RESULT_BASE;
    assign op_sel = (wb_adr >= pwm_pkg::REG_OPERAND_BASE) && (wb_adr < pwm_pkg::REG_RESULT_BASE);
    assign res_sel = (wb_adr >= pwm_pkg::REG_RESULT_BASE) &&
                     (res_off < 5'(pwm_pkg::NUM_RESULT_WORDS));

    always_comb begin
        rd_data = '0;
        if (wb_adr == pwm_pkg::REG_CTRL)
            rd_data[1] = acc_q;
        else if (wb_adr == pwm_pkg::REG_STATUS)
            rd_data[1:0] = {done, busy};
        else if (op_sel)
            rd_data[W-1:0] = operand[op_off[3:0]];
        else if (res_sel)
            rd_data[W-1:0] = result[res_off[1:0]];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wb_ack <= 1'b0;
            wb_dat_r <= '0;
            zeroize <= 1'b0;
            acc_q <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            operand <= '0;
            result <= '0;
        end else begin
            wb_ack <= wb_req;
            zeroize <= zero_req;
            if (wb_req)
                wb_dat_r <= rd_data;
            if (ctrl_wr)
                acc_q <= wb_dat_w[1];
            if (wb_req && wb_we && op_sel)
                operand[op_off[3:0]] <= wb_dat_w[W-1:0];

            if (in_valid) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (out_valid && busy) begin
                busy <= 1'b0;
                done <= 1'b1;
                result <= {res1_s1, res1_s0, res0_s1, res0_s0};
            end

            // zeroize overrides everything above
            if (zero_req) begin
                busy <= 1'b0;
                done <= 1'b0;
                operand <= '0;
                result <= '0;
            end
        end
    end

    assign {u0_s1, u0_s0} = {operand[1], operand[0]};
    assign {u1_s1, u1_s0} = {operand[3], operand[2]};
    assign {v0_s1, v0_s0} = {operand[5], operand[4]};
    assign {v1_s1, v1_s0} = {operand[7], operand[6]};
    assign {w0_s1, w0_s0} = {operand[9], operand[8]};
    assign {w1_s1, w1_s0} = {operand[11], operand[10]};
    assign {zeta_s1, zeta_s0} = {operand[13], operand[12]};

endmodule

// File: rtl/pwm_top.sv
//----------------------------------------------------------------------
// masked pairwise multiplier top level
// register block, mask LFSR and pipeline
//----------------------------------------------------------------------
`timescale 1ns/1ns

module pwm_top #(
    parameter logic [63:0] MASK_SEED = 64'h3c5a_96e1_0f27_b4d9
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [pwm_pkg::WB_ADDR_WIDTH-1:0]  wb_adr,
    input  logic [31:0]                        wb_dat_w,
    output logic [31:0]                        wb_dat_r,
    output logic                               wb_ack
);

    localparam int unsigned W = pwm_pkg::COEFF_WIDTH;

    // pipeline control
    logic zeroize;
    logic in_valid;
    logic accumulate;
    logic out_valid;

    // operand and result shares
    logic [W-1:0] u0_s0, u0_s1, u1_s0, u1_s1;
    logic [W-1:0] v0_s0, v0_s1, v1_s0, v1_s1;
    logic [W-1:0] w0_s0, w0_s1, w1_s0, w1_s1;
    logic [W-1:0] zeta_s0, zeta_s1;
    logic [W-1:0] res0_s0, res0_s1, res1_s0, res1_s1;

    logic [pwm_pkg::NUM_RND-1:0][W-1:0] rnd;

    pwm_regs u_regs (.*);

    mask_lfsr #(
        .SEED(MASK_SEED)
    ) u_lfsr (
        .clk,
        .reset_n,
        .rnd
    );

    masked_pairwm u_pairwm (.*);

endmodule

// File: verification/pwm_tb.sv
//----------------------------------------------------------------------
// testbench for the masked pairwise multiplier top level
// Wishbone read/write tasks, stimulus table, reference model, checks
//----------------------------------------------------------------------
`timescale 1ns/1ns

module pwm_tb;

    localparam int unsigned Q = 3329;
    localparam int NUM_ROWS = 8;
    localparam int NUM_COLS = 8;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 300 + 1000;

    logic        clk;
    logic        reset_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [4:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    // columns u0 u1 v0 v1 w0 w1 zeta accumulate
    int unsigned stim [NUM_ROWS][NUM_COLS];
    int unsigned shares [14];
    int unsigned exp_c0;
    int unsigned exp_c1;
    int          error_count;
    int          cycle_count;
    integer      seed;

    pwm_top #(
        .MASK_SEED(64'h9e37_79b9_7f4a_7c15)
    ) pwm_top_inst (
        .clk, .reset_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
        $display("Something failed");
        $finish;
    end

    //------------------------------------------------------------------
    // bus access and checking
    //------------------------------------------------------------------
    // ack comes one cycle after the request
    task automatic wait_ack();
        int unsigned low_cycles;
        low_cycles = 0;
        @(negedge clk);
        while (!wb_ack) begin
            low_cycles++;
            @(negedge clk);
        end
        check("wb_ack delay in cycles", low_cycles, 1);
    endtask

    task automatic wb_write(input logic [4:0] adr, input logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b1;
        wb_adr <= adr;
        wb_dat_w <= data;
        wait_ack();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        // ack lasts one cycle only
        @(negedge clk);
        check("wb_ack after ack cycle", wb_ack, 0);
    endtask

    task automatic wb_read(input logic [4:0] adr, output int unsigned data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= 1'b0;
        wb_adr <= adr;
        wait_ack();
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(negedge clk);
        check("wb_ack after ack cycle", wb_ack, 0);
    endtask

    task automatic check(input string name, input int unsigned actual,
                         input int unsigned expected);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    // share 0 random below q, share 1 makes up the rest
    task automatic mask_value(input int unsigned value, output int unsigned s0,
                              output int unsigned s1);
        s0 = $unsigned($random(seed)) % Q;
        s1 = (value + Q - s0) % Q;
    endtask

    task automatic load_table();
        stim[0] = '{0, 0, 0, 0, 0, 0, 0, 0};
        stim[1] = '{3328, 3328, 3328, 3328, 3328, 3328, 3328, 1};
        stim[2] = '{17, 1234, 2000, 3000, 5, 9, 1, 0};
        stim[3] = '{1, 2, 3, 4, 5, 6, 17, 1};
        stim[4] = '{3328, 3328, 3328, 3328, 3328, 3328, 3328, 0};
        stim[5] = '{2500, 1700, 42, 3100, 1000, 2000, 1729, 1};
        stim[6] = '{0, 3328, 1, 0, 3328, 0, 2285, 1};
        stim[7] = '{1111, 2222, 3000, 123, 77, 3328, 1, 1};
    endtask

    // c0 = u0 v0 + u1 zeta v1 + w0, c1 = u0 v1 + u1 v0 + w1
    task automatic compute_expected(input int row);
        int unsigned zv1;
        int unsigned acc;
        zv1 = (stim[row][6] * stim[row][3]) % Q;
        acc = stim[row][7];
        exp_c0 = (stim[row][0] * stim[row][2] + stim[row][1] * zv1 + acc * stim[row][4]) % Q;
        exp_c1 = (stim[row][0] * stim[row][3] + stim[row][1] * stim[row][2]
                  + acc * stim[row][5]) % Q;
    endtask

    //------------------------------------------------------------------
    // test sequences
    //------------------------------------------------------------------
    task automatic read_results(output int unsigned res [4]);
        for (int k = 0; k < 4; k++)
            wb_read(pwm_pkg::REG_RESULT_BASE + 5'(k), res[k]);
    endtask

    task automatic run_row(input int row, input bit double_start);
        int unsigned rd;
        int unsigned ctrl;
        int unsigned res [4];
        int unsigned again [4];
        for (int k = 0; k < 7; k++)
            mask_value(stim[row][k], shares[2*k], shares[2*k+1]);
        for (int k = 0; k < 14; k++)
            wb_write(pwm_pkg::REG_OPERAND_BASE + 5'(k), shares[k]);
        for (int k = 0; k < 14; k++) begin
            wb_read(pwm_pkg::REG_OPERAND_BASE + 5'(k), rd);
            check($sformatf("operand word %0d", k), rd, shares[k]);
        end
        compute_expected(row);
        ctrl = (stim[row][7] << 1) | 32'd1;
        wb_write(pwm_pkg::REG_CTRL, ctrl);
        // second start lands while the first item is still in flight
        if (double_start)
            wb_write(pwm_pkg::REG_CTRL, ctrl);
        wb_read(pwm_pkg::REG_STATUS, rd);
        check("status busy after start", rd, 32'd1);
        while ((rd & 32'd2) == 0)
            wb_read(pwm_pkg::REG_STATUS, rd);
        check("status at done", rd, 32'd2);
        wb_read(pwm_pkg::REG_CTRL, rd);
        check("ctrl readback", rd, stim[row][7] << 1);
        read_results(res);
        for (int k = 0; k < 4; k++)
            check($sformatf("result share %0d below q", k), 32'(res[k] < Q), 32'd1);
        check($sformatf("row %0d c0", row), (res[0] + res[1]) % Q, exp_c0);
        check($sformatf("row %0d c1", row), (res[2] + res[3]) % Q, exp_c1);
        if (double_start) begin
            // long enough for a wrongly accepted start to come out
            repeat (pwm_pkg::PWM_LATENCY + 4) @(posedge clk);
            read_results(again);
            for (int k = 0; k < 4; k++)
                check($sformatf("result word %0d after ignored start", k), again[k], res[k]);
            wb_read(pwm_pkg::REG_STATUS, rd);
            check("status after ignored start", rd, 32'd2);
        end
    endtask

    task automatic check_unmapped();
        int unsigned rd;
        for (int a = 20; a < 32; a++) begin
            wb_read(5'(a), rd);
            check($sformatf("unmapped word %0d", a), rd, 32'd0);
        end
    endtask

    task automatic check_zeroize();
        int unsigned rd;
        wb_write(pwm_pkg::REG_CTRL, 32'd4);
        wb_read(pwm_pkg::REG_STATUS, rd);
        check("status after zeroize", rd, 32'd0);
        for (int k = 0; k < 18; k++) begin
            wb_read(pwm_pkg::REG_OPERAND_BASE + 5'(k), rd);
            check($sformatf("word %0d after zeroize", k + 2), rd, 32'd0);
        end
    endtask

    initial begin
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
        wb_adr <= '0;
        wb_dat_w <= '0;
        reset_n <= 1'b0;
        error_count = 0;
        seed = 32'heb8cc985;
        load_table();
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        check_unmapped();
        for (int row = 0; row < NUM_ROWS; row++)
            run_row(row, 1'b0);
        run_row(5, 1'b1);
        check_zeroize();
        run_row(3, 1'b0);

        $display("checks finished with %0d errors", error_count);
        if (error_count == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: compile.f
common/pwm_pkg.sv
rtl/mod_q_mult.sv
pairwm/masked_share_mult.sv
pairwm/masked_pairwm.sv
rtl/mask_lfsr.sv
rtl/pwm_regs.sv
rtl/pwm_top.sv
verification/pwm_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := pwm_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf $(OBJ_DIR)
